// File: Makefile
# Verilator simulation of arty_status

TOP := tb_arty_status

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf obj_dir

// File: bench/tb_ref.svh
/*
 * Reference rules and typed compares, included inside the testbench module.
 * Needs report_error to be declared before the include.
 */

`ifndef TB_REF_SVH
`define TB_REF_SVH

localparam logic [31:0] LCG_SEED = 32'h514e9512;

//==================================================
// Reference rules
//==================================================

// Numerical Recipes constants
function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
endfunction

// Offset 2 picks red, 1 green, 0 blue
function automatic board_pkg::led_bank_t bank_ref(input board_pkg::rgb_led_t rgb,
                                                  input int offset);
    board_pkg::led_bank_t bank;
    for (int led = 0; led < 4; led++) begin
        bank[led] = rgb[led * 3 + offset];
    end
    return bank;
endfunction

// Bits 2 to 0 of the status LEDs
function automatic logic [2:0] status_low_ref(input board_pkg::pio_led_t pio,
                                              input logic rst_n);
    return {!rst_n, pio[1], pio[0]};
endfunction

// Two sync stages, the count window, then the state edge
function automatic int release_cycles_ref(input int hold);
    return hold + 3;
endfunction

function automatic int assert_cycles_ref();
    return 3;
endfunction

function automatic int level_cycles_ref(input board_pkg::tick_count_t clk_hz);
    return int'(clk_hz / 2) + 1;
endfunction

//==================================================
// Typed compares
//==================================================
task automatic check_bank(input string what, input board_pkg::led_bank_t got,
                          input board_pkg::led_bank_t exp);
    if (got !== exp) begin
        report_error($sformatf("%s is %b, expected %b", what, got, exp));
    end
endtask

task automatic check_level(input string what, input logic got, input logic exp);
    if (got !== exp) begin
        report_error($sformatf("%s is %b, expected %b", what, got, exp));
    end
endtask

task automatic check_count(input string what, input int got, input int exp);
    if (got != exp) begin
        report_error($sformatf("%s is %0d cycles, expected %0d", what, got, exp));
    end
endtask

`endif

// File: bench/tb_arty_status.sv
/*
 * Testbench for arty_status with a 40 Hz clock parameter and a 16-cycle window.
 * Inputs change 2 ns after the rising edge. LED outputs are checked at the falling edge.
 */

module tb_arty_status;

    timeunit 1ns;
    timeprecision 100ps;

    localparam board_pkg::tick_count_t TB_CLK_FREQ_HZ = 32'd40;
    localparam int                     TB_HOLD_CYCLES = 16;

    logic                   cpu_clk;
    logic                   hard_rst_n;
    logic                   extn_rst_n_i;
    board_pkg::rgb_led_t    pio_led_rgb_i;
    board_pkg::pio_led_t    pio_led_i;
    logic                   sys_rst_n_o;
    board_pkg::led_bank_t   ledr_o;
    board_pkg::led_bank_t   ledg_o;
    board_pkg::led_bank_t   ledb_o;
    board_pkg::led_bank_t   status_led_o;
    logic [31:0]            lcg_state;
    int                     cycles;

    arty_status #(
        .CLK_FREQ_HZ (TB_CLK_FREQ_HZ),
        .HOLD_CYCLES (TB_HOLD_CYCLES)
    ) dut (
        .cpu_clk       (cpu_clk),
        .hard_rst_n    (hard_rst_n),
        .extn_rst_n_i  (extn_rst_n_i),
        .pio_led_rgb_i (pio_led_rgb_i),
        .pio_led_i     (pio_led_i),
        .sys_rst_n_o   (sys_rst_n_o),
        .ledr_o        (ledr_o),
        .ledg_o        (ledg_o),
        .ledb_o        (ledb_o),
        .status_led_o  (status_led_o)
    );

    always #20 cpu_clk = !cpu_clk;

    //==================================================
    // Failure reporting
    //==================================================
    task automatic report_error(input string msg);
        $display("[ERROR] %0d ns: %s", $time, msg);
        $display("Finished with errors");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic report_timeout(input string what, input int limit);
        $display("Timed out after %0d cycles waiting for %s", limit, what);
        $display("Finished with errors");
        $fatal(1, "stopped on timeout");
    endtask

    `include "tb_ref.svh"

    // One clock and then the 2 ns drive offset
    task automatic next_cycle();
        @(posedge cpu_clk);
        #2;
    endtask

    task automatic wait_sys_rst(input logic level, input int limit, output int count);
        count = 0;
        do begin
            if (count == limit) begin
                report_timeout("sys_rst_n_o to change", limit);
            end
            next_cycle();
            count++;
        end while (sys_rst_n_o !== level);
    endtask

    task automatic wait_heartbeat(input logic level, input int limit, output int count);
        count = 0;
        do begin
            if (count == limit) begin
                report_timeout("the heartbeat LED to toggle", limit);
            end
            next_cycle();
            count++;
        end while (status_led_o[3] !== level);
    endtask

    //==================================================
    // Per-cycle LED comparison
    //==================================================
    always @(negedge cpu_clk) begin : compare_leds
        logic [2:0] status_exp;
        status_exp = status_low_ref(pio_led_i, sys_rst_n_o);
        check_bank("red bank", ledr_o, bank_ref(pio_led_rgb_i, 2));
        check_bank("green bank", ledg_o, bank_ref(pio_led_rgb_i, 1));
        check_bank("blue bank", ledb_o, bank_ref(pio_led_rgb_i, 0));
        check_level("status LED 0", status_led_o[0], status_exp[0]);
        check_level("status LED 1", status_led_o[1], status_exp[1]);
        check_level("status LED 2", status_led_o[2], status_exp[2]);
        // Heartbeat is forced low during system reset
        if (!sys_rst_n_o) begin
            check_level("heartbeat in reset", status_led_o[3], 1'b0);
        end
    end

    //==================================================
    // Stimulus
    //==================================================
    initial begin
        cpu_clk       = 1'b0;
        hard_rst_n    = 1'b0;
        extn_rst_n_i  = 1'b0;
        pio_led_rgb_i = '0;
        pio_led_i     = '0;
        lcg_state     = LCG_SEED;
        repeat (10) @(posedge cpu_clk);
        #2;
        hard_rst_n = 1'b1;

        // Held in reset while the external input is low
        repeat (30) begin
            next_cycle();
            check_level("sys_rst_n_o held", sys_rst_n_o, 1'b0);
            check_level("status LED 2 in reset", status_led_o[2], 1'b1);
            check_level("heartbeat in reset", status_led_o[3], 1'b0);
        end

        // Clean release
        extn_rst_n_i = 1'b1;
        wait_sys_rst(1'b1, 100, cycles);
        check_count("release delay", cycles, release_cycles_ref(TB_HOLD_CYCLES));

        // Heartbeat period after the short first level
        wait_heartbeat(1'b1, 50, cycles);
        repeat (4) begin
            wait_heartbeat(!status_led_o[3], 100, cycles);
            check_count("heartbeat level", cycles, level_cycles_ref(TB_CLK_FREQ_HZ));
        end

        // Reassertion while running
        extn_rst_n_i = 1'b0;
        wait_sys_rst(1'b0, 20, cycles);
        check_count("assertion delay", cycles, assert_cycles_ref());
        check_level("heartbeat after reassertion", status_led_o[3], 1'b0);

        // Glitch inside the window restarts it
        extn_rst_n_i = 1'b1;
        repeat (10) begin
            next_cycle();
            check_level("sys_rst_n_o before glitch", sys_rst_n_o, 1'b0);
        end
        extn_rst_n_i = 1'b0;
        next_cycle();
        extn_rst_n_i = 1'b1;
        wait_sys_rst(1'b1, 100, cycles);
        check_count("release after glitch", cycles, release_cycles_ref(TB_HOLD_CYCLES));

        // Random LED words for the per-cycle comparison
        repeat (200) begin
            lcg_state     = lcg_next(lcg_state);
            pio_led_rgb_i = lcg_state[27:16];
            pio_led_i     = lcg_state[31:30];
            next_cycle();
        end
        next_cycle();

        $display("Finished with no errors");
        $finish;
    end

endmodule : tb_arty_status

// File: flist.f
+incdir+bench
src/board_pkg.sv
src/hold_counter.sv
src/heartbeat_timer.sv
src/rst_release_fsm.sv
src/arty_status.sv
bench/tb_arty_status.sv

// File: src/arty_status.sv
/*
 * Board reset and status logic. extn_rst_n_i is asynchronous to cpu_clk.
 * LED outputs are combinational from their inputs.
 */

module arty_status #(
    parameter board_pkg::tick_count_t CLK_FREQ_HZ = board_pkg::DEFAULT_CLK_FREQ_HZ,
    parameter int                     HOLD_CYCLES = board_pkg::DEFAULT_HOLD_CYCLES
) (
    input  logic                   cpu_clk,
    input  logic                   hard_rst_n,
    input  logic                   extn_rst_n_i,
    input  board_pkg::rgb_led_t    pio_led_rgb_i,
    input  board_pkg::pio_led_t    pio_led_i,
    output logic                   sys_rst_n_o,
    output board_pkg::led_bank_t   ledr_o,
    output board_pkg::led_bank_t   ledg_o,
    output board_pkg::led_bank_t   ledb_o,
    output board_pkg::led_bank_t   status_led_o
);

    // Two heartbeat toggles per second
    localparam board_pkg::tick_count_t RELOAD_VALUE = CLK_FREQ_HZ / 2;

    logic count_en;
    logic count_clr;
    logic hold_done;
    logic heartbeat;

    //==================================================
    // Reset conditioning
    //==================================================
    rst_release_fsm u_rst_fsm (
        .cpu_clk      (cpu_clk),
        .hard_rst_n   (hard_rst_n),
        .extn_rst_n_i (extn_rst_n_i),
        .hold_done_i  (hold_done),
        .count_en_o   (count_en),
        .count_clr_o  (count_clr),
        .sys_rst_n_o  (sys_rst_n_o)
    );

    hold_counter #(
        .HOLD_CYCLES (HOLD_CYCLES)
    ) u_hold_cnt (
        .cpu_clk     (cpu_clk),
        .hard_rst_n  (hard_rst_n),
        .count_en_i  (count_en),
        .count_clr_i (count_clr),
        .hold_done_o (hold_done)
    );

    // Runs from the generated reset, not the hard one
    heartbeat_timer #(
        .RELOAD_VALUE (RELOAD_VALUE)
    ) u_heartbeat (
        .cpu_clk     (cpu_clk),
        .sys_rst_n_i (sys_rst_n_o),
        .heartbeat_o (heartbeat)
    );

    //==================================================
    // LED wiring
    //==================================================
    always_comb begin
        for (int k = 0; k < 4; k++) begin
            ledr_o[k] = pio_led_rgb_i[3*k+2];
            ledg_o[k] = pio_led_rgb_i[3*k+1];
            ledb_o[k] = pio_led_rgb_i[3*k];
        end
    end

    // Board LEDs 4 to 7
    assign status_led_o = {heartbeat, !sys_rst_n_o, pio_led_i};

endmodule : arty_status

// File: src/board_pkg.sv
/*
 * Shared types and default constants for the board status block.
 * Defaults suit the board clock; simulation overrides them through the
 * top-level parameters.
 */

package board_pkg;

    //==================================================
    // Widths with a meaning
    //==================================================

    // Timer count or reload value, in clock cycles
    typedef logic [31:0] tick_count_t;

    // Interleaved RGB word: bit 3k+2 red k, 3k+1 green k, 3k blue k
    typedef logic [11:0] rgb_led_t;

    // One colour bank, also reused for the four status LEDs
    typedef logic [3:0]  led_bank_t;

    // Two plain LEDs
    typedef logic [1:0]  pio_led_t;

    //==================================================
    // Reset release state machine
    //==================================================
    typedef enum logic {
        RST_HELD = 1'b0,
        RST_RUN  = 1'b1
    } rst_state_e;

    //==================================================
    // Defaults for the top-level parameters
    //==================================================
    localparam tick_count_t DEFAULT_CLK_FREQ_HZ = 32'd25_000_000;
    localparam int          DEFAULT_HOLD_CYCLES = 16;

endpackage : board_pkg

// File: src/heartbeat_timer.sv
/*
 * Heartbeat toggle. Held low while sys_rst_n_i is low.
 * Each heartbeat level lasts RELOAD_VALUE+1 cycles; RELOAD_VALUE must be
 * nonzero.
 */

module heartbeat_timer #(
    parameter board_pkg::tick_count_t RELOAD_VALUE = 32'd12_500_000
) (
    input  logic cpu_clk,
    input  logic sys_rst_n_i,
    output logic heartbeat_o
);

    board_pkg::tick_count_t timer_q;
    logic                   tick_q;

    //==================================================
    // Reloading down-counter
    //==================================================
    always_ff @(posedge cpu_clk, negedge sys_rst_n_i) begin
        if (!sys_rst_n_i) begin
            timer_q <= '0;
            tick_q  <= 1'b0;
        end else if (timer_q == '0) begin
            timer_q <= RELOAD_VALUE;
            tick_q  <= 1'b1;
        end else begin
            timer_q <= timer_q - 1'b1;
            tick_q  <= 1'b0;
        end
    end

    // Toggle on the edge after each tick
    always_ff @(posedge cpu_clk, negedge sys_rst_n_i) begin
        if (!sys_rst_n_i) begin
            heartbeat_o <= 1'b0;
        end else if (tick_q) begin
            heartbeat_o <= !heartbeat_o;
        end
    end

    //==================================================
    // Checks
    //==================================================
    a_tick_single : assert property (
        @(posedge cpu_clk) disable iff (!sys_rst_n_i)
        tick_q |=> !tick_q
    ) else $error("heartbeat tick high for two cycles");

endmodule : heartbeat_timer

// File: src/hold_counter.sv
/*
 * Saturating count of consecutive enabled cycles. Clear wins over enable.
 * HOLD_CYCLES must be at least 1.
 */

module hold_counter #(
    parameter int HOLD_CYCLES = 16
) (
    input  logic cpu_clk,
    input  logic hard_rst_n,
    input  logic count_en_i,
    input  logic count_clr_i,
    output logic hold_done_o
);

    localparam int CNT_W = $clog2(HOLD_CYCLES + 1);
    localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(HOLD_CYCLES);

    logic [CNT_W-1:0] count_q;

    always_ff @(posedge cpu_clk, negedge hard_rst_n) begin
        if (!hard_rst_n) begin
            count_q <= '0;
        end else if (count_clr_i) begin
            count_q <= '0;
        end else if (count_en_i && (count_q != CNT_MAX)) begin
            count_q <= count_q + 1'b1;
        end
    end

    // Terminal flag held while saturated
    assign hold_done_o = (count_q == CNT_MAX);

    a_count_in_range : assert property (
        @(posedge cpu_clk) disable iff (!hard_rst_n)
        count_q <= CNT_MAX
    ) else $error("hold count above HOLD_CYCLES");

endmodule : hold_counter

// File: src/rst_release_fsm.sv
/*
 * External reset conditioning. extn_rst_n_i may be fully asynchronous.
 * sys_rst_n_o asserts two edges after the input is sampled low and
 * releases only after HOLD_CYCLES consecutive synchronized high cycles.
 */

module rst_release_fsm (
    input  logic cpu_clk,
    input  logic hard_rst_n,
    input  logic extn_rst_n_i,
    input  logic hold_done_i,
    output logic count_en_o,
    output logic count_clr_o,
    output logic sys_rst_n_o
);

    //==================================================
    // Two-flop synchronizer
    //==================================================
    logic [1:0]             extn_sync_q;
    logic                   extn_rst_n_sync;

    board_pkg::rst_state_e  state_q;
    board_pkg::rst_state_e  state_d;

    always_ff @(posedge cpu_clk, negedge hard_rst_n) begin
        if (!hard_rst_n) begin
            extn_sync_q <= 2'b00;
        end else begin
            extn_sync_q <= {extn_sync_q[0], extn_rst_n_i};
        end
    end

    assign extn_rst_n_sync = extn_sync_q[1];

    //==================================================
    // Held / run state machine
    //==================================================
    always_comb begin
        state_d     = state_q;
        count_en_o  = 1'b0;
        count_clr_o = 1'b1;
        case (state_q)
            board_pkg::RST_HELD: begin
                // Count while high and restart the window on any low
                count_en_o  = extn_rst_n_sync;
                count_clr_o = !extn_rst_n_sync;
                if (hold_done_i && extn_rst_n_sync) begin
                    state_d = board_pkg::RST_RUN;
                end
            end
            board_pkg::RST_RUN: begin
                if (!extn_rst_n_sync) begin
                    state_d = board_pkg::RST_HELD;
                end
            end
            default: begin
                state_d = board_pkg::RST_HELD;
            end
        endcase
    end

    // Output register tracks the state so it never glitches
    always_ff @(posedge cpu_clk, negedge hard_rst_n) begin
        if (!hard_rst_n) begin
            state_q     <= board_pkg::RST_HELD;
            sys_rst_n_o <= 1'b0;
        end else begin
            state_q     <= state_d;
            sys_rst_n_o <= (state_d == board_pkg::RST_RUN);
        end
    end

    //==================================================
    // Checks
    //==================================================

    // Release needs a high synchronized input on the edge that releases
    a_no_release_while_low : assert property (
        @(posedge cpu_clk) disable iff (!hard_rst_n)
        $rose(sys_rst_n_o) |-> $past(extn_rst_n_sync)
    ) else $error("sys_rst_n_o released while synchronized reset was low");

    a_en_clr_exclusive : assert property (
        @(posedge cpu_clk) disable iff (!hard_rst_n)
        !(count_en_o && count_clr_o)
    ) else $error("count enable and clear asserted together");

endmodule : rst_release_fsm
